// ==== flist.f ====
hdl/cpu_pkg.sv
hdl/regfile_read_if.sv
hdl/pipe_reg.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/cpu_core.sv
test/cpu_core_chk.sv
test/cpu_core_monitor.sv
test/cpu_core_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/regfile_read_if.sv
      - hdl/pipe_reg.sv
      - hdl/register_file.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/result_stage.sv
      - hdl/cpu_core.sv
  - target: test
    files:
      - test/cpu_core_chk.sv
      - test/cpu_core_monitor.sv
      - test/cpu_core_tb.sv

// ==== test/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb
	import cpu_pkg::*;
();

	localparam int RETIRE_W     = 16;
	localparam int DRAIN_LIMIT  = 20;
	localparam int RANDOM_COUNT = 400;

	logic                clk;
	logic                arst_n;
	logic                inst_valid;
	logic [15:0]         inst;
	logic                wb_valid;
	logic [2:0]          wb_addr;
	logic [15:0]         wb_data;
	logic                fault;
	logic [RETIRE_W-1:0] retired;
	logic [2:0]          test_id;
	logic                busy;
	logic [31:0]         error_count;
	logic [31:0]         check_count;
	logic [31:0]         lfsr;
	int                  timeouts;

	cpu_core #(.RETIRE_W(RETIRE_W)) cpu_core_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.inst_valid(inst_valid),
		.inst      (inst),
		.wb_valid  (wb_valid),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.fault     (fault),
		.retired   (retired)
	);

	cpu_core_monitor #(.RETIRE_W(RETIRE_W)) u_monitor (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.test_id    (test_id),
		.wb_valid   (wb_valid),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.fault      (fault),
		.retired    (retired),
		.busy       (busy),
		.error_count(error_count),
		.check_count(check_count)
	);

	bind cpu_core cpu_core_chk #(.RETIRE_W(RETIRE_W)) u_chk (
		.clk        (clk),
		.arst_n     (arst_n),
		.wb_valid   (wb_valid),
		.fault      (fault),
		.retired    (retired),
		.res_valid  (res_in_valid),
		.res_illegal(res_in_data.illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Weighted opcode table whose last three codes are illegal
	function automatic logic [4:0] pick_opcode(input logic [3:0] idx);
		case (idx)
			4'd0: return OP_ADDU;
			4'd1: return OP_SUBU;
			4'd2: return OP_AND;
			4'd3: return OP_OR;
			4'd4: return OP_XOR;
			4'd5: return OP_SLT;
			4'd6: return OP_SLLV;
			4'd7: return OP_SRAV;
			4'd8, 4'd9: return OP_ADDIU;
			4'd10, 4'd11: return OP_LI;
			4'd12: return OP_NOP;
			4'd13: return 5'b00000;
			4'd14: return 5'b11111;
			default: return 5'b10000;
		endcase
	endfunction

	function automatic logic [15:0] encode_r(input logic [4:0] opc, input logic [2:0] rx,
			input logic [2:0] ry, input logic [2:0] rz);
		return {opc, rx, ry, rz, 2'b00};
	endfunction

	function automatic logic [15:0] encode_i(input logic [4:0] opc, input logic [2:0] rx,
			input logic [7:0] imm);
		return {opc, rx, imm};
	endfunction

	function automatic logic [15:0] random_inst();
		logic [4:0] opc;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;
		opc = pick_opcode(4'(take_bits(4)));
		rx  = 3'(take_bits(3));
		if (opc == OP_ADDIU || opc == OP_LI) begin
			return encode_i(opc, rx, 8'(take_bits(8)));
		end
		ry = 3'(take_bits(3));
		rz = 3'(take_bits(3));
		return encode_r(opc, rx, ry, rz);
	endfunction

	task automatic issue(input logic [15:0] word);
		@(negedge clk);
		inst_valid = 1'b1;
		inst       = word;
	endtask

	// Idle cycle with garbage on inst
	task automatic gap();
		@(negedge clk);
		inst_valid = 1'b0;
		inst       = 16'(take_bits(16));
	endtask

	task automatic drain();
		int waited;
		@(negedge clk);
		inst_valid = 1'b0;
		waited = 0;
		while (busy && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (busy) begin
			$display("Timeout: instructions still in flight after %0d cycles", DRAIN_LIMIT);
			timeouts++;
		end
	endtask

	initial begin
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		test_id    = 3'd0;
		timeouts   = 0;
		lfsr       = 32'hc97156b4;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		for (int i = 0; i < 8; i++) begin
			issue(encode_r(OP_ADDU, 3'(i), 3'(7 - i), 3'(i)));
		end
		drain();

		test_id = 3'd1;
		issue(encode_i(OP_LI, 3'd1, 8'h7f));
		issue(encode_i(OP_LI, 3'd2, 8'hff));
		issue(encode_i(OP_ADDIU, 3'd3, 8'h80));
		issue(encode_i(OP_ADDIU, 3'd4, 8'hff));
		issue(encode_i(OP_ADDIU, 3'd1, 8'h01));
		drain();

		// One apart hits forwarding, two apart hits the write-through
		test_id = 3'd2;
		issue(encode_i(OP_LI, 3'd5, 8'h03));
		issue(encode_i(OP_ADDIU, 3'd5, 8'h04));
		issue(encode_r(OP_ADDU, 3'd5, 3'd5, 3'd6));
		issue(encode_r(OP_SUBU, 3'd6, 3'd5, 3'd7));
		issue(encode_r(OP_SLLV, 3'd5, 3'd7, 3'd0));
		issue(encode_r(OP_SRAV, 3'd5, 3'd0, 3'd1));
		issue(encode_r(OP_SLT, 3'd1, 3'd0, 3'd2));
		issue(encode_r(OP_XOR, 3'd2, 3'd2, 3'd2));
		drain();

		test_id = 3'd3;
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			if (take_bits(3) == 0) begin
				gap();
			end else begin
				issue(random_inst());
			end
		end
		drain();

		test_id = 3'd4;
		issue(encode_r(5'b00000, 3'd1, 3'd2, 3'd3));
		issue(encode_r(OP_NOP, 3'd0, 3'd0, 3'd0));
		issue(encode_r(5'b11111, 3'd4, 3'd5, 3'd6));
		issue(encode_r(OP_ADDU, 3'd1, 3'd2, 3'd3));
		issue(encode_r(5'b10000, 3'd3, 3'd3, 3'd3));
		drain();

		test_id = 3'd5;
		issue(encode_i(OP_LI, 3'd6, 8'h5a));
		repeat (4) gap();
		issue(encode_r(OP_ADDU, 3'd6, 3'd6, 3'd7));
		gap();
		drain();

		$display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
			check_count, error_count, cpu_core_i.u_chk.fail_count, timeouts);
		if (error_count == 0 && cpu_core_i.u_chk.fail_count == 0 && timeouts == 0
				&& check_count > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== test/cpu_core_monitor.sv ====
`timescale 1ns/1ps

module cpu_core_monitor
	import cpu_pkg::*;
#(
	parameter int RETIRE_W = 16
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                inst_valid,
	input  logic [15:0]         inst,
	input  logic [2:0]          test_id,
	input  logic                wb_valid,
	input  logic [2:0]          wb_addr,
	input  logic [15:0]         wb_data,
	input  logic                fault,
	input  logic [RETIRE_W-1:0] retired,
	output logic                busy,
	output logic [31:0]         error_count,
	output logic [31:0]         check_count
);

	// Sampling edge to the edge that sees the registered outputs
	localparam int LATENCY = 3;

	typedef struct packed {
		logic                live;
		logic [2:0]          test;
		logic                wb;
		reg_addr_t           addr;
		word_t               data;
		logic                fault;
		logic [RETIRE_W-1:0] retired;
	} exp_t;

	word_t               model [REG_COUNT];
	logic [RETIRE_W-1:0] retire_count;
	exp_t                exp_q [$];

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0: return "reset_read";
			3'd1: return "immediates";
			3'd2: return "dependencies";
			3'd3: return "random_mix";
			3'd4: return "illegal_nop";
			default: return "gaps";
		endcase
	endfunction

	// Instruction-set model stepped one instruction at a time
	function automatic exp_t predict(input logic valid, input word_t word, input logic [2:0] id);
		exp_t       e;
		word_t      a;
		word_t      b;
		word_t      res;
		logic [7:0] imm;
		e      = '0;
		e.test = id;
		e.live = valid;
		if (valid) begin
			a      = model[word[RX_HI:RX_LO]];
			b      = model[word[RY_HI:RY_LO]];
			imm    = word[IMM_HI:IMM_LO];
			res    = '0;
			e.wb   = 1'b1;
			e.addr = word[RZ_HI:RZ_LO];
			case (opcode_e'(word[OPC_HI:OPC_LO]))
				OP_ADDU: res = a + b;
				OP_SUBU: res = a - b;
				OP_AND: res = a & b;
				OP_OR: res = a | b;
				OP_XOR: res = a ^ b;
				OP_SLT: res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
				OP_SLLV: res = b << a[3:0];
				OP_SRAV: res = $signed(b) >>> a[3:0];
				OP_ADDIU: begin
					res    = a + {{8{imm[7]}}, imm};
					e.addr = word[RX_HI:RX_LO];
				end
				OP_LI: begin
					res    = {8'h00, imm};
					e.addr = word[RX_HI:RX_LO];
				end
				OP_NOP: e.wb = 1'b0;
				default: begin
					e.wb    = 1'b0;
					e.fault = 1'b1;
				end
			endcase
			if (e.wb) begin
				e.data        = res;
				model[e.addr] = res;
			end
			if (!e.fault) begin
				retire_count = retire_count + 1'b1;
			end
		end
		e.retired = retire_count;
		return e;
	endfunction

	task automatic compare(input string test, input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("ERROR %s %s: expected %h, actual %h", test, field, expected, actual);
		end
	endtask

	initial begin
		error_count = 0;
		check_count = 0;
	end

	always @(posedge clk or negedge arst_n) begin
		exp_t e;
		if (!arst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				model[i] = '0;
			end
			retire_count = '0;
			exp_q.delete();
			// Idle slots check the reset values of the outputs
			for (int i = 0; i < LATENCY; i++) begin
				exp_q.push_back('0);
			end
			busy = 1'b0;
		end else begin
			exp_q.push_back(predict(inst_valid, inst, test_id));
			e = exp_q.pop_front();
			compare(test_name(e.test), "wb_valid", e.wb, wb_valid);
			compare(test_name(e.test), "fault", e.fault, fault);
			compare(test_name(e.test), "retired", e.retired, retired);
			if (e.wb) begin
				compare(test_name(e.test), "wb_addr", e.addr, wb_addr);
				compare(test_name(e.test), "wb_data", e.data, wb_data);
			end
			busy = 1'b0;
			foreach (exp_q[k]) begin
				if (exp_q[k].live) begin
					busy = 1'b1;
				end
			end
		end
	end

endmodule

// ==== test/cpu_core_chk.sv ====
`timescale 1ns/1ps

module cpu_core_chk #(
	parameter int RETIRE_W = 16
) (
	input logic                clk,
	input logic                arst_n,
	input logic                wb_valid,
	input logic                fault,
	input logic [RETIRE_W-1:0] retired,
	input logic                res_valid,
	input logic                res_illegal
);

	logic [1:0] since_reset;
	int         fail_count;

	initial fail_count = 0;

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			since_reset <= '0;
		end else if (since_reset != 2'd3) begin
			since_reset <= since_reset + 2'd1;
		end
	end

	wb_fault_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(wb_valid && fault))
		else begin
			fail_count++;
			$error("wb_valid and fault are high in the same cycle");
		end

	// Step of one, and only after a legal instruction left the result stage
	retire_step: assert property (@(posedge clk) disable iff (!arst_n)
		(retired != $past(retired)) |->
		((retired - $past(retired)) == RETIRE_W'(1)) && $past(res_valid && !res_illegal))
		else begin
			fail_count++;
			$error("retired changed without a legal retirement or by more than one");
		end

	quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
		(since_reset != 2'd3) |-> !wb_valid)
		else begin
			fail_count++;
			$error("wb_valid high within three cycles of reset");
		end

endmodule

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
	import cpu_pkg::*;
#(
	parameter int RETIRE_W = 16
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                inst_valid,
	input  logic [15:0]         inst,
	output logic                wb_valid,
	output logic [2:0]          wb_addr,
	output logic [15:0]         wb_data,
	output logic                fault,
	output logic [RETIRE_W-1:0] retired
);

	regfile_read_if rd_if ();

	logic         rf_we;
	reg_addr_t    rf_waddr;
	word_t        rf_wdata;

	logic         dec_valid;
	dec_payload_t dec_data;
	logic         exe_in_valid;
	dec_payload_t exe_in_data;

	logic         exe_valid;
	res_payload_t exe_data;
	logic         res_in_valid;
	res_payload_t res_in_data;

	register_file u_regfile (
		.clk   (clk),
		.arst_n(arst_n),
		.rd    (rd_if.file),
		.we    (rf_we),
		.waddr (rf_waddr),
		.wdata (rf_wdata)
	);

	decode_stage u_decode (
		.inst_valid(inst_valid),
		.inst      (inst),
		.rd        (rd_if.reader),
		.out_valid (dec_valid),
		.out_data  (dec_data)
	);

	pipe_reg #(.payload_t(dec_payload_t)) u_dec_exe (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (dec_valid),
		.in_data  (dec_data),
		.out_valid(exe_in_valid),
		.out_data (exe_in_data)
	);

	// Forwarding source is the instruction held in the result stage
	execute_stage u_execute (
		.in_valid (exe_in_valid),
		.in_data  (exe_in_data),
		.fwd_valid(res_in_valid),
		.fwd      (res_in_data),
		.out_valid(exe_valid),
		.out_data (exe_data)
	);

	pipe_reg #(.payload_t(res_payload_t)) u_exe_res (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (exe_valid),
		.in_data  (exe_data),
		.out_valid(res_in_valid),
		.out_data (res_in_data)
	);

	result_stage #(.RETIRE_W(RETIRE_W)) u_result (
		.clk     (clk),
		.arst_n  (arst_n),
		.in_valid(res_in_valid),
		.in_data (res_in_data),
		.we      (rf_we),
		.waddr   (rf_waddr),
		.wdata   (rf_wdata),
		.wb_valid(wb_valid),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.fault   (fault),
		.retired (retired)
	);

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ps

module result_stage
	import cpu_pkg::*;
#(
	parameter int RETIRE_W = 16
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                in_valid,
	input  res_payload_t        in_data,
	output logic                we,
	output reg_addr_t           waddr,
	output word_t               wdata,
	output logic                wb_valid,
	output reg_addr_t           wb_addr,
	output word_t               wb_data,
	output logic                fault,
	output logic [RETIRE_W-1:0] retired
);

	assign we    = in_valid && in_data.reg_write;
	assign waddr = in_data.dest;
	assign wdata = in_data.value;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			wb_addr  <= '0;
			wb_data  <= '0;
			fault    <= 1'b0;
			retired  <= '0;
		end else begin
			wb_valid <= we;
			fault    <= in_valid && in_data.illegal;
			if (we) begin
				wb_addr <= waddr;
				wb_data <= wdata;
			end
			// NOP counts, illegal codes do not
			if (in_valid && !in_data.illegal) begin
				retired <= retired + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
	import cpu_pkg::*;
(
	input  logic         in_valid,
	input  dec_payload_t in_data,
	input  logic         fwd_valid,
	input  res_payload_t fwd,
	output logic         out_valid,
	output res_payload_t out_data
);

	logic  fwd_hit1;
	logic  fwd_hit2;
	word_t a;
	word_t b;
	word_t result;

	logic [SHAMT_W-1:0] shamt;

	// Result of the instruction one ahead, not yet in the register file
	assign fwd_hit1 = fwd_valid && fwd.reg_write && !in_data.op1_zero
		&& fwd.dest == in_data.src1;
	assign fwd_hit2 = fwd_valid && fwd.reg_write && !in_data.use_imm
		&& fwd.dest == in_data.src2;

	assign a = fwd_hit1 ? fwd.value : in_data.op1;
	assign b = fwd_hit2 ? fwd.value : in_data.op2;

	assign shamt = a[SHAMT_W-1:0];

	always_comb begin
		unique case (in_data.alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: begin
				if ($signed(a) < $signed(b)) begin
					result = word_t'(1);
				end else begin
					result = '0;
				end
			end
			ALU_SLL: result = b << shamt;
			ALU_SRA: result = word_t'($signed(b) >>> shamt);
			default: result = '0;
		endcase
	end

	assign out_valid          = in_valid;
	assign out_data.reg_write = in_data.reg_write;
	assign out_data.dest      = in_data.dest;
	assign out_data.value     = result;
	assign out_data.illegal   = in_data.illegal;

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
	import cpu_pkg::*;
(
	input  logic          inst_valid,
	input  word_t         inst,
	regfile_read_if.reader rd,
	output logic          out_valid,
	output dec_payload_t  out_data
);

	opcode_e          opcode;
	reg_addr_t        rx;
	reg_addr_t        ry;
	reg_addr_t        rz;
	logic [IMM_W-1:0] imm8;
	word_t            imm_sext;
	word_t            imm_zext;

	assign opcode = opcode_e'(inst[OPC_HI:OPC_LO]);
	assign rx     = inst[RX_HI:RX_LO];
	assign ry     = inst[RY_HI:RY_LO];
	assign rz     = inst[RZ_HI:RZ_LO];
	assign imm8   = inst[IMM_HI:IMM_LO];

	assign imm_sext = {{(DATA_W - IMM_W){imm8[IMM_W-1]}}, imm8};
	assign imm_zext = {{(DATA_W - IMM_W){1'b0}}, imm8};

	// Both ports always read rx and ry, unused data is ignored
	assign rd.rd_addr1 = rx;
	assign rd.rd_addr2 = ry;

	assign out_valid = inst_valid;

	always_comb begin
		out_data.alu_op    = ALU_ADD;
		out_data.src1      = rx;
		out_data.src2      = ry;
		out_data.use_imm   = 1'b0;
		out_data.op1_zero  = 1'b0;
		out_data.reg_write = 1'b1;
		out_data.dest      = rz;
		out_data.illegal   = 1'b0;

		unique case (opcode)
			OP_NOP: out_data.reg_write = 1'b0;
			OP_ADDU: out_data.alu_op = ALU_ADD;
			OP_SUBU: out_data.alu_op = ALU_SUB;
			OP_AND: out_data.alu_op = ALU_AND;
			OP_OR: out_data.alu_op = ALU_OR;
			OP_XOR: out_data.alu_op = ALU_XOR;
			OP_SLT: out_data.alu_op = ALU_SLT;
			OP_SLLV: out_data.alu_op = ALU_SLL;
			OP_SRAV: out_data.alu_op = ALU_SRA;
			OP_ADDIU: begin
				out_data.use_imm = 1'b1;
				out_data.dest    = rx;
			end
			OP_LI: begin
				out_data.use_imm  = 1'b1;
				out_data.op1_zero = 1'b1;
				out_data.dest     = rx;
			end
			default: begin
				out_data.reg_write = 1'b0;
				out_data.illegal   = 1'b1;
			end
		endcase

		out_data.op1 = out_data.op1_zero ? '0 : rd.rd_data1;
		if (!out_data.use_imm) begin
			out_data.op2 = rd.rd_data2;
		end else if (opcode == OP_LI) begin
			out_data.op2 = imm_zext;
		end else begin
			out_data.op2 = imm_sext;
		end
	end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	regfile_read_if.file          rd,
	input  logic                  we,
	input  reg_addr_t             waddr,
	input  word_t                 wdata
);

	word_t regs [REG_COUNT];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through so a read in the same cycle sees the value being written
	always_comb begin
		if (we && waddr == rd.rd_addr1) begin
			rd.rd_data1 = wdata;
		end else begin
			rd.rd_data1 = regs[rd.rd_addr1];
		end
	end

	always_comb begin
		if (we && waddr == rd.rd_addr2) begin
			rd.rd_data2 = wdata;
		end else begin
			rd.rd_data2 = regs[rd.rd_addr2];
		end
	end

endmodule

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= in_data;
	end

endmodule

// ==== hdl/regfile_read_if.sv ====
`timescale 1ns/1ps

interface regfile_read_if
	import cpu_pkg::*;
();

	reg_addr_t rd_addr1;
	word_t     rd_data1;
	reg_addr_t rd_addr2;
	word_t     rd_data2;

	modport reader (
		output rd_addr1,
		output rd_addr2,
		input  rd_data1,
		input  rd_data2
	);

	modport file (
		input  rd_addr1,
		input  rd_addr2,
		output rd_data1,
		output rd_data2
	);

endinterface

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

	localparam int DATA_W    = 16;
	localparam int REG_AW    = 3;
	localparam int REG_COUNT = 1 << REG_AW;
	localparam int SHAMT_W   = $clog2(DATA_W);

	// Instruction field positions
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 11;
	localparam int RX_HI  = 10;
	localparam int RX_LO  = 8;
	localparam int RY_HI  = 7;
	localparam int RY_LO  = 5;
	localparam int RZ_HI  = 4;
	localparam int RZ_LO  = 2;
	localparam int IMM_HI = 7;
	localparam int IMM_LO = 0;

	localparam int OPC_W = OPC_HI - OPC_LO + 1;
	localparam int IMM_W = IMM_HI - IMM_LO + 1;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	// Any code not listed here is illegal
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 5'b00001,
		OP_ADDIU = 5'b01001,
		OP_LI    = 5'b01101,
		OP_SLLV  = 5'b10100,
		OP_SRAV  = 5'b10111,
		OP_AND   = 5'b11000,
		OP_OR    = 5'b11001,
		OP_XOR   = 5'b11010,
		OP_SLT   = 5'b11011,
		OP_ADDU  = 5'b11100,
		OP_SUBU  = 5'b11101
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,
		ALU_SLL = 3'd6,
		ALU_SRA = 3'd7
	} alu_op_e;

	typedef struct packed {
		alu_op_e   alu_op;
		word_t     op1;
		word_t     op2;
		reg_addr_t src1;
		reg_addr_t src2;
		// op2 holds an immediate
		logic      use_imm;
		// op1 holds the constant zero of LI
		logic      op1_zero;
		logic      reg_write;
		reg_addr_t dest;
		logic      illegal;
	} dec_payload_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t dest;
		word_t     value;
		logic      illegal;
	} res_payload_t;

endpackage
